//--- src.f
+incdir+hdl
hdl/mc_cmd_pkg.sv
hdl/mc_reg_pkg.sv
hdl/mem_cmd_if.sv
hdl/port_arbiter.sv
hdl/rd_resp_queue.sv
hdl/mem_backend.sv
hdl/status_regs.sv
hdl/mem_ctrl_top.sv
bench/tb_mem_ctrl.sv

//--- run_sim.sh
#!/bin/sh
# build and run tb_mem_ctrl with Verilator, verdict from sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f src.f --top-module tb_mem_ctrl -o tb_sim
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
fi

if grep -q "^NO ERRORS$" sim.log; then
    echo "PASS"
    exit 0
else
    echo "FAIL, see sim.log"
    exit 1
fi

//--- bench/tb_mem_ctrl.sv
`timescale 1ns/10ps
`include "mc_cfg.svh"

module tb_mem_ctrl;

    localparam int WINDOW = 24; // address range used by the traffic
    localparam int TOTAL_REQS = 24 + 32 + 120 + 26;
    localparam int CYCLE_LIMIT = 20 * TOTAL_REQS + 200;

    localparam int FILL_WR = 0;
    localparam int RAND_WR = 1;
    localparam int RAND_RD = 2;
    localparam int READ_BACK = 3;
    localparam int MIXED = 4;

    localparam int RSP_ON = 0;
    localparam int RSP_OFF = 1;
    localparam int RSP_RAND = 2;

    logic                  ui_clk;
    logic                  reset;
    logic                  calib_done;
    logic [1:0]            req_valid;
    logic [1:0]            req_ready;
    logic [1:0]            req_write;
    logic [`MC_ADDR_W-1:0] req_addr [2];
    logic [`MC_DATA_W-1:0] req_wdata [2];
    logic [`MC_STRB_W-1:0] req_strb [2];
    logic [1:0]            rsp_valid;
    logic [1:0]            rsp_ready;
    logic [`MC_DATA_W-1:0] rsp_data [2];
    logic                  reg_sel;
    logic                  reg_enable;
    logic                  reg_write;
    logic [1:0]            reg_addr;
    logic [31:0]           reg_wdata;
    logic [31:0]           reg_rdata;
    logic                  reg_ack;

    logic [`MC_DATA_W-1:0] model_mem [WINDOW];
    logic [`MC_DATA_W-1:0] exp_q0 [$]; // expected read data for port 0
    logic [`MC_DATA_W-1:0] exp_q1 [$];
    int                    addr_q [$]; // written addresses for read back
    logic [1:0]            acc = 2'b00; // handshakes seen at the last negedge
    int                    issued [2];
    int                    target [2];
    int                    mode [2];
    int                    cycles = 0;
    int                    calib_wait = 0;
    int                    rd_total = 0;
    int                    wr_total = 0;
    int                    rd_phase = 0;
    int                    wr_phase = 0;
    int                    last_grant = 1;
    bit                    fair_on = 1'b0;
    string                 phase_name = "reset";
    logic [31:0]           rdata;
    logic [31:0]           scratch_val;

    mem_ctrl_top i_dut (
        .ui_clk       (ui_clk),
        .reset        (reset),
        .calib_done   (calib_done),
        .p0_req_valid (req_valid[0]),
        .p0_req_ready (req_ready[0]),
        .p0_req_write (req_write[0]),
        .p0_req_addr  (req_addr[0]),
        .p0_req_wdata (req_wdata[0]),
        .p0_req_strb  (req_strb[0]),
        .p1_req_valid (req_valid[1]),
        .p1_req_ready (req_ready[1]),
        .p1_req_write (req_write[1]),
        .p1_req_addr  (req_addr[1]),
        .p1_req_wdata (req_wdata[1]),
        .p1_req_strb  (req_strb[1]),
        .p0_rsp_valid (rsp_valid[0]),
        .p0_rsp_ready (rsp_ready[0]),
        .p0_rsp_data  (rsp_data[0]),
        .p1_rsp_valid (rsp_valid[1]),
        .p1_rsp_ready (rsp_ready[1]),
        .p1_rsp_data  (rsp_data[1]),
        .reg_sel      (reg_sel),
        .reg_enable   (reg_enable),
        .reg_write    (reg_write),
        .reg_addr     (reg_addr),
        .reg_wdata    (reg_wdata),
        .reg_rdata    (reg_rdata),
        .reg_ack      (reg_ack)
    );

    initial begin
        ui_clk = 1'b0;
        forever #20 ui_clk = ~ui_clk;
    end

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_rsp(input string name, input mc_cmd_pkg::rd_rsp_t exp,
                             input mc_cmd_pkg::rd_rsp_t act);
        if (act !== exp) begin
            report_error($sformatf("mismatch %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_reg(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            report_error($sformatf("mismatch %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic record_request(input int n);
        int a;
        a = int'(req_addr[n]);
        if (req_write[n]) begin
            for (int b = 0; b < `MC_STRB_W; b++) begin
                if (req_strb[n][b]) begin
                    model_mem[a][b*8 +: 8] = req_wdata[n][b*8 +: 8];
                end
            end
            wr_total++;
            wr_phase++;
        end else begin
            if (n == 0) begin
                exp_q0.push_back(model_mem[a]); // contents at the handshake
            end else begin
                exp_q1.push_back(model_mem[a]);
            end
            rd_total++;
            rd_phase++;
        end
    endtask

    task automatic check_response(input int n);
        mc_cmd_pkg::rd_rsp_t exp_rsp;
        mc_cmd_pkg::rd_rsp_t act_rsp;
        if (rsp_valid[n]) begin
            if ((n == 0 && exp_q0.size() == 0) || (n == 1 && exp_q1.size() == 0)) begin
                report_error($sformatf("port %0d shows a response with no read outstanding", n));
            end else if (rsp_ready[n]) begin
                exp_rsp.port = (n == 1);
                if (n == 0) begin
                    exp_rsp.data = exp_q0.pop_front();
                end else begin
                    exp_rsp.data = exp_q1.pop_front();
                end
                act_rsp.port = rsp_valid[1]; // port named by the raised valid
                act_rsp.data = rsp_data[n];
                check_rsp(phase_name, exp_rsp, act_rsp);
            end
        end
    endtask

    // mid-cycle sampling of inputs driven at posedge + 1 ns
    always @(negedge ui_clk) begin
        int g;
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            report_error($sformatf("timeout after %0d cycles in %s", cycles, phase_name));
        end
        if (!reset) begin
            if (!calib_done) begin
                calib_wait++;
                if (req_ready != 2'b00) begin
                    report_error("request accepted before calibration finished");
                end
            end
            acc = req_valid & req_ready;
            if (acc == 2'b11) begin
                report_error("both ports granted in the same cycle");
            end
            for (int n = 0; n < 2; n++) begin
                if (acc[n]) begin
                    record_request(n);
                end
            end
            if (acc != 2'b00) begin
                g = acc[1] ? 1 : 0;
                if (fair_on && req_valid == 2'b11 && g == last_grant) begin
                    report_error($sformatf("port %0d granted twice in a row", g));
                end
                last_grant = g;
            end
            for (int n = 0; n < 2; n++) begin
                check_response(n);
            end
        end
    end

    task automatic make_req(input int n);
        int a;
        req_valid[n] = 1'b1;
        req_wdata[n] = $urandom();
        req_strb[n]  = `MC_STRB_W'($urandom());
        a = int'($urandom_range(0, WINDOW - 1));
        case (mode[n])
            FILL_WR: begin
                req_write[n] = 1'b1;
                req_strb[n]  = '1;
                a = 2 * issued[n] + n; // ports interleave over the window
            end
            RAND_WR: begin
                req_write[n] = 1'b1;
                addr_q.push_back(a);
            end
            RAND_RD: req_write[n] = 1'b0;
            READ_BACK: begin
                req_write[n] = 1'b0;
                a = addr_q.pop_front();
            end
            default: req_write[n] = 1'($urandom_range(0, 1));
        endcase
        req_addr[n] = `MC_ADDR_W'(a);
    endtask

    task automatic step(input int rsp_mode);
        @(posedge ui_clk);
        #1;
        for (int n = 0; n < 2; n++) begin
            if (acc[n]) begin
                issued[n]++;
            end
            if (issued[n] >= target[n]) begin
                req_valid[n] = 1'b0;
            end else if (acc[n] || !req_valid[n]) begin
                if (mode[n] == MIXED && $urandom_range(0, 3) == 0) begin
                    req_valid[n] = 1'b0; // idle gap
                end else begin
                    make_req(n);
                end
            end
            case (rsp_mode)
                RSP_ON:  rsp_ready[n] = 1'b1;
                RSP_OFF: rsp_ready[n] = 1'b0;
                default: rsp_ready[n] = 1'($urandom_range(0, 1));
            endcase
        end
    endtask

    function automatic bit phase_done();
        return issued[0] >= target[0] && issued[1] >= target[1] &&
               exp_q0.size() == 0 && exp_q1.size() == 0;
    endfunction

    task automatic set_phase(input string name, input int n0, input int m0,
                             input int n1, input int m1);
        phase_name = name;
        target[0]  = n0;
        target[1]  = n1;
        mode[0]    = m0;
        mode[1]    = m1;
        issued[0]  = 0;
        issued[1]  = 0;
        rd_phase   = 0;
        wr_phase   = 0;
    endtask

    // max_cycles of 0 runs until all requests are done and drained
    task automatic run_cycles(input int rsp_mode, input int max_cycles);
        int c;
        c = 0;
        do begin
            step(rsp_mode);
            c++;
        end while (!phase_done() && (max_cycles == 0 || c < max_cycles));
    endtask

    task automatic reg_access(input logic wr, input mc_reg_pkg::reg_idx_t idx,
                              input logic [31:0] wdata, output logic [31:0] rd);
        @(posedge ui_clk);
        #1;
        reg_sel    = 1'b1;
        reg_enable = 1'b0;
        reg_write  = wr;
        reg_addr   = idx;
        reg_wdata  = wdata;
        @(posedge ui_clk);
        #1;
        reg_enable = 1'b1; // access phase
        @(negedge ui_clk);
        if (!reg_ack) begin
            report_error("reg_ack missing in the access phase");
        end
        rd = reg_rdata;
        @(posedge ui_clk);
        #1;
        reg_sel    = 1'b0;
        reg_enable = 1'b0;
        reg_write  = 1'b0;
    endtask

    initial begin
        void'($urandom(29117));
        reset      = 1'b1;
        req_valid  = 2'b00;
        req_write  = 2'b00;
        rsp_ready  = 2'b00;
        reg_sel    = 1'b0;
        reg_enable = 1'b0;
        reg_write  = 1'b0;
        reg_addr   = 2'd0;
        reg_wdata  = '0;
        for (int n = 0; n < 2; n++) begin
            req_addr[n]  = '0;
            req_wdata[n] = '0;
            req_strb[n]  = '0;
        end
        set_phase("reset", 0, RAND_RD, 0, RAND_RD);
        repeat (2) @(posedge ui_clk);
        #1;
        reset = 1'b0;

        reg_access(1'b0, mc_reg_pkg::reg_status, 32'd0, rdata);
        check_reg("status before calibration", 32'd0, rdata);

        // port 0 wins first with both ports valid from inside calibration
        fair_on    = 1'b1;
        last_grant = 1;
        set_phase("fill and fairness", 12, FILL_WR, 12, FILL_WR);
        run_cycles(RSP_ON, 0);
        fair_on = 1'b0;
        check_reg("calibration delay", `MC_CALIB_CYCLES, calib_wait);
        reg_access(1'b0, mc_reg_pkg::reg_status, 32'd0, rdata);
        check_reg("status after calibration", 32'd1, rdata);

        set_phase("single port write", 16, RAND_WR, 0, RAND_RD);
        run_cycles(RSP_ON, 0);
        set_phase("single port read back", 16, READ_BACK, 0, RAND_RD);
        run_cycles(RSP_ON, 0);

        set_phase("random traffic", 60, MIXED, 60, MIXED);
        run_cycles(RSP_RAND, 0);

        set_phase("read back-pressure", 16, RAND_RD, 10, RAND_WR);
        run_cycles(RSP_OFF, 40);
        if (rd_phase > `MC_QUEUE_DEPTH) begin
            report_error($sformatf("%0d reads accepted with no response taken", rd_phase));
        end
        check_reg("writes under back-pressure", 32'd10, wr_phase);
        run_cycles(RSP_RAND, 0);

        phase_name = "registers";
        reg_access(1'b0, mc_reg_pkg::reg_rd_count, 32'd0, rdata);
        check_reg("read counter", rd_total, rdata);
        reg_access(1'b0, mc_reg_pkg::reg_wr_count, 32'd0, rdata);
        check_reg("write counter", wr_total, rdata);
        scratch_val = $urandom();
        reg_access(1'b1, mc_reg_pkg::reg_scratch, scratch_val, rdata);
        reg_access(1'b0, mc_reg_pkg::reg_scratch, 32'd0, rdata);
        check_reg("scratch", scratch_val, rdata);
        reg_access(1'b1, mc_reg_pkg::reg_rd_count, 32'd0, rdata);
        reg_access(1'b0, mc_reg_pkg::reg_rd_count, 32'd0, rdata);
        check_reg("read counter cleared", 32'd0, rdata);

        $display("NO ERRORS");
        $finish;
    end

endmodule

//--- hdl/mem_ctrl_top.sv
`timescale 1ns/10ps
`include "mc_cfg.svh"

module mem_ctrl_top (
    input  logic                  ui_clk,
    input  logic                  reset,
    output logic                  calib_done,
    input  logic                  p0_req_valid,
    output logic                  p0_req_ready,
    input  logic                  p0_req_write,
    input  logic [`MC_ADDR_W-1:0] p0_req_addr,
    input  logic [`MC_DATA_W-1:0] p0_req_wdata,
    input  logic [`MC_STRB_W-1:0] p0_req_strb,
    input  logic                  p1_req_valid,
    output logic                  p1_req_ready,
    input  logic                  p1_req_write,
    input  logic [`MC_ADDR_W-1:0] p1_req_addr,
    input  logic [`MC_DATA_W-1:0] p1_req_wdata,
    input  logic [`MC_STRB_W-1:0] p1_req_strb,
    output logic                  p0_rsp_valid,
    input  logic                  p0_rsp_ready,
    output logic [`MC_DATA_W-1:0] p0_rsp_data,
    output logic                  p1_rsp_valid,
    input  logic                  p1_rsp_ready,
    output logic [`MC_DATA_W-1:0] p1_rsp_data,
    input  logic                  reg_sel,
    input  logic                  reg_enable,
    input  logic                  reg_write,
    input  logic [1:0]            reg_addr,
    input  logic [31:0]           reg_wdata,
    output logic [31:0]           reg_rdata,
    output logic                  reg_ack
);

    logic                  rd_space;
    logic [`MC_DATA_W-1:0] rd_data;
    logic                  rd_data_valid;

    mem_cmd_if mc_bus ();

    assign calib_done = mc_bus.calib_done;

    port_arbiter i_arbiter (
        .ui_clk       (ui_clk),
        .reset        (reset),
        .p0_req_valid (p0_req_valid),
        .p0_req_ready (p0_req_ready),
        .p0_req_write (p0_req_write),
        .p0_req_addr  (p0_req_addr),
        .p0_req_wdata (p0_req_wdata),
        .p0_req_strb  (p0_req_strb),
        .p1_req_valid (p1_req_valid),
        .p1_req_ready (p1_req_ready),
        .p1_req_write (p1_req_write),
        .p1_req_addr  (p1_req_addr),
        .p1_req_wdata (p1_req_wdata),
        .p1_req_strb  (p1_req_strb),
        .rd_space     (rd_space),
        .bus          (mc_bus.arb)
    );

    mem_backend i_backend (
        .ui_clk        (ui_clk),
        .reset         (reset),
        .bus           (mc_bus.mem),
        .rd_data       (rd_data),
        .rd_data_valid (rd_data_valid)
    );

    rd_resp_queue i_resp_queue (
        .ui_clk        (ui_clk),
        .reset         (reset),
        .bus           (mc_bus.mon),
        .rd_data       (rd_data),
        .rd_data_valid (rd_data_valid),
        .rd_space      (rd_space),
        .p0_rsp_valid  (p0_rsp_valid),
        .p0_rsp_ready  (p0_rsp_ready),
        .p0_rsp_data   (p0_rsp_data),
        .p1_rsp_valid  (p1_rsp_valid),
        .p1_rsp_ready  (p1_rsp_ready),
        .p1_rsp_data   (p1_rsp_data)
    );

    status_regs i_regs (
        .ui_clk     (ui_clk),
        .reset      (reset),
        .reg_sel    (reg_sel),
        .reg_enable (reg_enable),
        .reg_write  (reg_write),
        .reg_addr   (reg_addr),
        .reg_wdata  (reg_wdata),
        .reg_rdata  (reg_rdata),
        .reg_ack    (reg_ack),
        .bus        (mc_bus.mon)
    );

endmodule

//--- hdl/status_regs.sv
`timescale 1ns/10ps

module status_regs (
    input  logic        ui_clk,
    input  logic        reset,
    input  logic        reg_sel,
    input  logic        reg_enable,
    input  logic        reg_write,
    input  logic [1:0]  reg_addr,
    input  logic [31:0] reg_wdata,
    output logic [31:0] reg_rdata,
    output logic        reg_ack,
    mem_cmd_if.mon      bus
);

    mc_reg_pkg::reg_idx_t     idx;
    mc_reg_pkg::status_word_t status;
    logic [31:0]              rd_count;
    logic [31:0]              wr_count;
    logic [31:0]              scratch;
    logic                     wr_en;
    logic                     xfer;

    assign idx     = mc_reg_pkg::reg_idx_t'(reg_addr);
    assign reg_ack = reg_sel & reg_enable; // access phase
    assign wr_en   = reg_ack & reg_write;
    assign xfer    = bus.valid & bus.ready;

    always_ff @(posedge ui_clk) begin
        if (reset) begin
            rd_count <= '0;
            wr_count <= '0;
            scratch  <= '0;
        end else begin
            if (wr_en && idx == mc_reg_pkg::reg_rd_count) begin
                rd_count <= '0;
            end else if (xfer && bus.cmd.op == mc_cmd_pkg::op_read) begin
                rd_count <= rd_count + 1'b1;
            end
            if (wr_en && idx == mc_reg_pkg::reg_wr_count) begin
                wr_count <= '0;
            end else if (xfer && bus.cmd.op == mc_cmd_pkg::op_write) begin
                wr_count <= wr_count + 1'b1;
            end
            if (wr_en && idx == mc_reg_pkg::reg_scratch) begin
                scratch <= reg_wdata;
            end
        end
    end

    always_comb begin
        status            = '0;
        status.calib_done = bus.calib_done;
        case (idx)
            mc_reg_pkg::reg_status:   reg_rdata = status;
            mc_reg_pkg::reg_rd_count: reg_rdata = rd_count;
            mc_reg_pkg::reg_wr_count: reg_rdata = wr_count;
            default:                  reg_rdata = scratch;
        endcase
    end

endmodule

//--- hdl/mem_backend.sv
`timescale 1ns/10ps
`include "mc_cfg.svh"

module mem_backend (
    input  logic                  ui_clk,
    input  logic                  reset,
    mem_cmd_if.mem                bus,
    output logic [`MC_DATA_W-1:0] rd_data,
    output logic                  rd_data_valid
);

    localparam int LAT = `MC_READ_LAT;
    localparam int WORDS = 1 << `MC_ADDR_W;
    localparam int CNT_W = $clog2(`MC_CALIB_CYCLES + 1);

    logic [`MC_DATA_W-1:0] mem [WORDS];
    logic [`MC_DATA_W-1:0] pipe_data [LAT];
    logic [LAT-1:0]        pipe_vld;
    logic [CNT_W-1:0]      calib_cnt;
    logic                  calib_done;
    logic                  fire;
    logic                  wr_fire;
    logic                  rd_fire;

    assign bus.calib_done = calib_done;
    assign bus.ready      = calib_done; // no stall once calibrated

    assign fire    = bus.valid & bus.ready;
    assign wr_fire = fire & (bus.cmd.op == mc_cmd_pkg::op_write);
    assign rd_fire = fire & (bus.cmd.op == mc_cmd_pkg::op_read);

    always_ff @(posedge ui_clk) begin
        if (reset) begin
            calib_cnt  <= '0;
            calib_done <= 1'b0;
        end else if (!calib_done) begin
            calib_cnt <= calib_cnt + 1'b1;
            if (calib_cnt == CNT_W'(`MC_CALIB_CYCLES - 1)) begin
                calib_done <= 1'b1;
            end
        end
    end

    // byte merge under strobe
    always_ff @(posedge ui_clk) begin
        if (wr_fire) begin
            for (int b = 0; b < `MC_STRB_W; b++) begin
                if (bus.cmd.payload.wr.strb[b]) begin
                    mem[bus.cmd.addr][b*8 +: 8] <= bus.cmd.payload.wr.data[b*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge ui_clk) begin
        pipe_data[0] <= mem[bus.cmd.addr];
        for (int s = 1; s < LAT; s++) begin
            pipe_data[s] <= pipe_data[s-1];
        end
    end

    always_ff @(posedge ui_clk) begin
        if (reset) begin
            pipe_vld <= '0;
        end else begin
            pipe_vld <= {pipe_vld[LAT-2:0], rd_fire};
        end
    end

    assign rd_data       = pipe_data[LAT-1];
    assign rd_data_valid = pipe_vld[LAT-1];

endmodule

//--- hdl/rd_resp_queue.sv
`timescale 1ns/10ps
`include "mc_cfg.svh"

module rd_resp_queue (
    input  logic                  ui_clk,
    input  logic                  reset,
    mem_cmd_if.mon                bus,
    input  logic [`MC_DATA_W-1:0] rd_data,
    input  logic                  rd_data_valid,
    output logic                  rd_space,
    output logic                  p0_rsp_valid,
    input  logic                  p0_rsp_ready,
    output logic [`MC_DATA_W-1:0] p0_rsp_data,
    output logic                  p1_rsp_valid,
    input  logic                  p1_rsp_ready,
    output logic [`MC_DATA_W-1:0] p1_rsp_data
);

    localparam int DEPTH = `MC_QUEUE_DEPTH;
    localparam int AW = $clog2(DEPTH);
    localparam logic [AW:0] FULL = DEPTH[AW:0];

    mc_cmd_pkg::port_id_t  tag_mem  [DEPTH];
    logic [`MC_DATA_W-1:0] data_mem [DEPTH];

    logic [AW:0]         tag_wp;
    logic [AW:0]         data_wp;
    logic [AW:0]         rd_ptr; // both FIFOs pop together
    logic [AW:0]         credits;
    logic                tag_push;
    logic                tag_empty;
    logic                data_empty;
    logic                rsp_valid;
    logic                pop;
    mc_cmd_pkg::rd_rsp_t head;

    assign tag_push = bus.valid & bus.ready & (bus.cmd.op == mc_cmd_pkg::op_read);

    // outstanding reads, issued but not yet handed back
    assign credits  = tag_wp - rd_ptr;
    assign rd_space = (credits != FULL);

    assign tag_empty  = (tag_wp == rd_ptr);
    assign data_empty = (data_wp == rd_ptr);
    assign rsp_valid  = ~tag_empty & ~data_empty;

    assign head.port = tag_mem[rd_ptr[AW-1:0]];
    assign head.data = data_mem[rd_ptr[AW-1:0]];

    // head tag picks the port, in command order
    assign p0_rsp_valid = rsp_valid & (head.port == 1'b0);
    assign p1_rsp_valid = rsp_valid & (head.port == 1'b1);
    assign p0_rsp_data  = head.data;
    assign p1_rsp_data  = head.data;

    assign pop = (p0_rsp_valid & p0_rsp_ready) | (p1_rsp_valid & p1_rsp_ready);

    always_ff @(posedge ui_clk) begin
        if (tag_push) begin
            tag_mem[tag_wp[AW-1:0]] <= bus.cmd.payload.rd.port;
        end
        if (rd_data_valid) begin
            data_mem[data_wp[AW-1:0]] <= rd_data;
        end
    end

    always_ff @(posedge ui_clk) begin
        if (reset) begin
            tag_wp  <= '0;
            data_wp <= '0;
            rd_ptr  <= '0;
        end else begin
            if (tag_push) begin
                tag_wp <= tag_wp + 1'b1;
            end
            // never overruns, data count stays below tag count
            if (rd_data_valid) begin
                data_wp <= data_wp + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

//--- hdl/port_arbiter.sv
`timescale 1ns/10ps
`include "mc_cfg.svh"

module port_arbiter (
    input  logic                  ui_clk,
    input  logic                  reset,
    input  logic                  p0_req_valid,
    output logic                  p0_req_ready,
    input  logic                  p0_req_write,
    input  logic [`MC_ADDR_W-1:0] p0_req_addr,
    input  logic [`MC_DATA_W-1:0] p0_req_wdata,
    input  logic [`MC_STRB_W-1:0] p0_req_strb,
    input  logic                  p1_req_valid,
    output logic                  p1_req_ready,
    input  logic                  p1_req_write,
    input  logic [`MC_ADDR_W-1:0] p1_req_addr,
    input  logic [`MC_DATA_W-1:0] p1_req_wdata,
    input  logic [`MC_STRB_W-1:0] p1_req_strb,
    input  logic                  rd_space,
    mem_cmd_if.arb                bus
);

    logic [1:0]            elig;
    mc_cmd_pkg::port_id_t  prio; // winner when both are eligible
    mc_cmd_pkg::port_id_t  sel;
    logic                  fire;
    logic                  win_write;
    logic [`MC_ADDR_W-1:0] win_addr;
    logic [`MC_DATA_W-1:0] win_wdata;
    logic [`MC_STRB_W-1:0] win_strb;
    mc_cmd_pkg::mem_cmd_t  cmd;

    // reads held back while the response queue is out of credits
    assign elig[0] = p0_req_valid & (p0_req_write | rd_space);
    assign elig[1] = p1_req_valid & (p1_req_write | rd_space);

    assign sel  = (&elig) ? prio : elig[1];
    assign fire = bus.valid & bus.ready;

    assign bus.valid    = bus.calib_done & (|elig);
    assign p0_req_ready = fire & (sel == 1'b0);
    assign p1_req_ready = fire & (sel == 1'b1);

    assign win_write = sel ? p1_req_write : p0_req_write;
    assign win_addr  = sel ? p1_req_addr  : p0_req_addr;
    assign win_wdata = sel ? p1_req_wdata : p0_req_wdata;
    assign win_strb  = sel ? p1_req_strb  : p0_req_strb;

    always_comb begin
        cmd.op   = win_write ? mc_cmd_pkg::op_write : mc_cmd_pkg::op_read;
        cmd.addr = win_addr;
        if (win_write) begin
            cmd.payload.wr.strb = win_strb;
            cmd.payload.wr.data = win_wdata;
        end else begin
            cmd.payload.rd.port = sel; // read tag for the response queue
            cmd.payload.rd.pad  = '0;
        end
    end

    assign bus.cmd = cmd;

    always_ff @(posedge ui_clk) begin
        if (reset) begin
            prio <= 1'b0;
        end else if (fire) begin
            prio <= ~sel; // other port first next time
        end
    end

endmodule

//--- hdl/mem_cmd_if.sv
`timescale 1ns/10ps

interface mem_cmd_if;

    mc_cmd_pkg::mem_cmd_t cmd;
    logic                 valid;
    logic                 ready;
    logic                 calib_done;

    modport arb (output cmd, output valid, input ready, input calib_done);

    modport mem (input cmd, input valid, output ready, output calib_done);

    modport mon (input cmd, input valid, input ready, input calib_done);

endinterface

//--- hdl/mc_reg_pkg.sv
package mc_reg_pkg;

    typedef enum logic [1:0] {
        reg_status   = 2'd0,
        reg_rd_count = 2'd1,
        reg_wr_count = 2'd2,
        reg_scratch  = 2'd3
    } reg_idx_t;

    typedef struct packed {
        logic [30:0] reserved; // reads as zero
        logic        calib_done;
    } status_word_t;

endpackage

//--- hdl/mc_cmd_pkg.sv
`include "mc_cfg.svh"

package mc_cmd_pkg;

    typedef logic port_id_t; // 0 or 1, issuing peer port

    typedef enum logic {
        op_read  = 1'b0,
        op_write = 1'b1
    } cmd_op_t;

    typedef struct packed {
        logic [`MC_STRB_W-1:0] strb;
        logic [`MC_DATA_W-1:0] data;
    } wr_payload_t;

    typedef struct packed {
        port_id_t                          port;
        logic [`MC_STRB_W+`MC_DATA_W-2:0]  pad; // fills up to write payload width
    } rd_payload_t;

    // decoded by op: write data with mask, or read tag
    typedef union packed {
        wr_payload_t wr;
        rd_payload_t rd;
    } cmd_payload_u;

    typedef struct packed {
        cmd_op_t               op;
        logic [`MC_ADDR_W-1:0] addr;
        cmd_payload_u          payload;
    } mem_cmd_t;

    typedef struct packed {
        port_id_t              port;
        logic [`MC_DATA_W-1:0] data;
    } rd_rsp_t;

endpackage

//--- hdl/mc_cfg.svh
`ifndef MC_CFG_SVH
`define MC_CFG_SVH

// word address, 1K words
`define MC_ADDR_W 10

`define MC_DATA_W 32

`define MC_STRB_W (`MC_DATA_W/8)

// cycles from read command transfer to returned data
`define MC_READ_LAT 4

// tag queue and data FIFO share this depth
`define MC_QUEUE_DEPTH 8

// calibration delay after reset release
`define MC_CALIB_CYCLES 16

`endif
